/* ddr_ctrl.f */
+incdir+rtl
rtl/ddr_ctrl_pkg.sv
rtl/ddr_refresh_timer.sv
rtl/ddr_bank_tracker.sv
rtl/ddr_cmd_fsm.sv
rtl/ddr_resp_tracker.sv
rtl/ddr_ctrl_top.sv
verification/ddr_ctrl_tb.sv

/* rtl/ddr_bank_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_ctrl_params.svh"

module ddr_bank_tracker
    import ddr_ctrl_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_i,
    input  wire bank_update_t update_i,
    input  wire ddr_bank_t    bank_i,
    input  wire ddr_row_t     row_i,
    output logic              row_hit_o,
    output logic              bank_open_o,
    output logic              any_open_o
);

    localparam int unsigned BANKS = `DDR_BANKS;

    // Open flag per bank
    logic [BANKS-1:0] open_q;
    // Active row per bank, valid only while open
    ddr_row_t         row_q [BANKS];

    // --------------------------------------------------
    // Table update
    // --------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            open_q <= '0;
        else if (update_i.close_all)
            open_q <= '0;
        else if (update_i.close_one)
            open_q[update_i.bank] <= 1'b0;
        else if (update_i.open_one)
            open_q[update_i.bank] <= 1'b1;
    end

    always_ff @(posedge clk_i)
    begin
        if (update_i.open_one)
            row_q[update_i.bank] <= update_i.row;
    end

    // --------------------------------------------------
    // Lookup for the current request
    // --------------------------------------------------
    assign bank_open_o = open_q[bank_i];
    // Stale row content is masked by the open flag
    assign row_hit_o   = bank_open_o && (row_q[bank_i] == row_i);
    assign any_open_o  = |open_q;

    // FSM only activates a bank that it has closed or never opened
    open_targets_closed_bank: assert property (
        @(posedge clk_i) disable iff (rst_i)
        update_i.open_one |-> !open_q[update_i.bank]
    );

endmodule

`default_nettype wire

/* rtl/ddr_cmd_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_cmd_fsm
    import ddr_ctrl_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_i,
    input  wire logic      req_valid_i,
    input  wire host_req_t req_i,
    input  wire logic      cmd_accept_i,
    input  wire logic      refresh_pending_i,
    input  wire logic      row_hit_i,
    input  wire logic      bank_open_i,
    input  wire logic      any_open_i,
    input  wire logic      id_space_i,
    output ddr_cmd_t       cmd_o,
    output logic           req_accept_o,
    output logic           refresh_done_o,
    output logic           push_o,
    output logic           write_issued_o,
    output bank_update_t   update_o,
    output ddr_bank_t      bank_o,
    output ddr_row_t       row_o
);

    ctrl_state_e state_q;
    ctrl_state_e next_state;
    // Final state after ACTIVATE or PRECHARGE
    ctrl_state_e target_q;
    ctrl_state_e target_d;
    ctrl_state_e access_state;

    ddr_col_t    col;
    ddr_bank_t   bank;
    ddr_row_t    row;
    logic        req_go;
    logic        refresh_target;

    // --------------------------------------------------
    // Address split, row-bank-column order
    // --------------------------------------------------
    // Burst-aligned column, low three bits zero
    assign col  = {req_i.addr[10:4], 3'b000};
    assign bank = req_i.addr[13:11];
    assign row  = req_i.addr[28:14];

    assign bank_o = bank;
    assign row_o  = row;

    // Only start when a response slot is free
    assign req_go         = req_valid_i && (req_i.rd || req_i.wr) && id_space_i;
    assign access_state   = req_i.rd ? ST_READ : ST_WRITE;
    assign refresh_target = (target_q == ST_REFRESH);

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb
    begin
        next_state = state_q;
        target_d   = target_q;
        case (state_q)
            ST_INIT:
            begin
                // Wait for the first refresh tick
                if (refresh_pending_i)
                    next_state = ST_IDLE;
            end
            ST_IDLE:
            begin
                // Refresh has priority, close rows first if any are open
                if (refresh_pending_i)
                begin
                    next_state = any_open_i ? ST_PRECHARGE : ST_REFRESH;
                    target_d   = ST_REFRESH;
                end
                else if (req_go)
                begin
                    target_d = access_state;
                    if (row_hit_i)
                        next_state = access_state;
                    // Row conflict
                    else if (bank_open_i)
                        next_state = ST_PRECHARGE;
                    else
                        next_state = ST_ACTIVATE;
                end
            end
            ST_ACTIVATE:  next_state = target_q;
            ST_PRECHARGE: next_state = refresh_target ? ST_REFRESH : ST_ACTIVATE;
            ST_READ,
            ST_WRITE,
            ST_REFRESH:   next_state = ST_IDLE;
            default:      next_state = ST_IDLE;
        endcase
    end

    // State moves only with an accepted command
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q  <= ST_INIT;
            target_q <= ST_IDLE;
        end
        else if (cmd_accept_i)
        begin
            state_q  <= next_state;
            target_q <= target_d;
        end
    end

    // --------------------------------------------------
    // Command encoding
    // --------------------------------------------------
    always_comb
    begin
        cmd_o.cmd  = CMD_NOP;
        cmd_o.bank = '0;
        cmd_o.addr = '0;
        case (state_q)
            ST_ACTIVATE:
            begin
                cmd_o.cmd  = CMD_ACTIVE;
                cmd_o.bank = bank;
                cmd_o.addr = row;
            end
            ST_READ,
            ST_WRITE:
            begin
                cmd_o.cmd  = (state_q == ST_READ) ? CMD_READ : CMD_WRITE;
                cmd_o.bank = bank;
                cmd_o.addr = ddr_addr_t'(col);
                // Row stays open, no auto-precharge
                cmd_o.addr[DDR_AP_BIT] = 1'b0;
            end
            ST_PRECHARGE:
            begin
                cmd_o.cmd = CMD_PRECHARGE;
                // All banks ahead of refresh, else just the request bank
                if (refresh_target)
                    cmd_o.addr[DDR_AP_BIT] = 1'b1;
                else
                    cmd_o.bank = bank;
            end
            ST_REFRESH:   cmd_o.cmd = CMD_REFRESH;
            default:      cmd_o.cmd = CMD_NOP;
        endcase
    end

    // Handshakes tied to accepted commands
    assign req_accept_o   = (state_q == ST_READ || state_q == ST_WRITE) && cmd_accept_i;
    assign push_o         = req_accept_o;
    assign write_issued_o = (state_q == ST_WRITE) && cmd_accept_i;
    assign refresh_done_o = (state_q == ST_REFRESH) && cmd_accept_i;

    // Open-row table follows accepted ACTIVATE and PRECHARGE
    assign update_o.open_one  = (state_q == ST_ACTIVATE) && cmd_accept_i;
    assign update_o.close_one = (state_q == ST_PRECHARGE) && !refresh_target && cmd_accept_i;
    assign update_o.close_all = (state_q == ST_PRECHARGE) && refresh_target && cmd_accept_i;
    assign update_o.bank      = bank;
    assign update_o.row       = row;

    // Host accept only for a presented request, in the access state of its kind
    accept_on_access: assert property (
        @(posedge clk_i) disable iff (rst_i)
        req_accept_o |-> req_valid_i && (state_q == (req_i.rd ? ST_READ : ST_WRITE))
    );

endmodule

`default_nettype wire

/* rtl/ddr_ctrl_params.svh */
`ifndef DDR_CTRL_PARAMS_SVH
`define DDR_CTRL_PARAMS_SVH

// --------------------------------------------------
// DDR3 geometry
// --------------------------------------------------

// Column, bank and row address widths
`define DDR_COL_W           10
`define DDR_BANK_W          3
`define DDR_ROW_W           15

// One open-row slot per bank
`define DDR_BANKS           8

// --------------------------------------------------
// Refresh timing, in controller clock cycles
// --------------------------------------------------

// Delay from reset to the first refresh tick, shortened for simulation
`define DDR_START_DELAY     40

// Interval between refresh ticks, shortened for simulation
`define DDR_REFRESH_CYCLES  300
`define DDR_REFRESH_CNT_W   20

// --------------------------------------------------
// Response path
// --------------------------------------------------

// Outstanding request IDs held for in-order responses
`define ID_FIFO_DEPTH       8

`endif

/* rtl/ddr_ctrl_pkg.sv */
`default_nettype none

`include "ddr_ctrl_params.svh"

package ddr_ctrl_pkg;

    // Address fields of the DDR3 device
    typedef logic [`DDR_ROW_W-1:0]  ddr_row_t;
    typedef logic [`DDR_BANK_W-1:0] ddr_bank_t;
    typedef logic [`DDR_COL_W-1:0]  ddr_col_t;
    // DFI address bus, as wide as a row
    typedef logic [`DDR_ROW_W-1:0]  ddr_addr_t;

    // Host side
    typedef logic [31:0]            host_addr_t;
    typedef logic [15:0]            req_id_t;
    typedef logic [127:0]           rd_data_t;

    // Address bit 10: all banks on PRECHARGE, auto-precharge on READ/WRITE
    localparam int unsigned DDR_AP_BIT = 10;

    // RAS_n, CAS_n, WE_n style command encoding
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001
    } ddr_cmd_e;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_ACTIVATE,
        ST_READ,
        ST_WRITE,
        ST_PRECHARGE,
        ST_REFRESH
    } ctrl_state_e;

    typedef struct packed {
        ddr_cmd_e   cmd;
        ddr_bank_t  bank;
        ddr_addr_t  addr;
    } ddr_cmd_t;

    typedef struct packed {
        logic       rd;
        logic       wr;
        host_addr_t addr;
        req_id_t    id;
    } host_req_t;

    typedef struct packed {
        req_id_t    id;
        rd_data_t   rd_data;
    } host_resp_t;

    // Open-row table update from the FSM
    typedef struct packed {
        logic       open_one;
        logic       close_one;
        logic       close_all;
        ddr_bank_t  bank;
        ddr_row_t   row;
    } bank_update_t;

endpackage

`default_nettype wire

/* rtl/ddr_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_ctrl_top
    import ddr_ctrl_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_i,
    // Host port
    input  wire logic      req_valid_i,
    input  wire host_req_t req_i,
    output logic           req_accept_o,
    output logic           resp_valid_o,
    output host_resp_t     resp_o,
    // Sequencer port
    output ddr_cmd_t       cmd_o,
    input  wire logic      cmd_accept_i,
    input  wire logic      rd_valid_i,
    input  wire rd_data_t  rd_data_i
);

    logic         refresh_pending;
    logic         refresh_done;
    logic         row_hit;
    logic         bank_open;
    logic         any_open;
    logic         id_space;
    logic         push;
    logic         write_issued;
    bank_update_t bank_update;
    ddr_bank_t    lookup_bank;
    ddr_row_t     lookup_row;

    // --------------------------------------------------
    // Refresh, state machine, bank table, responses
    // --------------------------------------------------
    ddr_refresh_timer u_refresh_timer (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .refresh_done_i    (refresh_done),
        .refresh_pending_o (refresh_pending)
    );

    ddr_cmd_fsm u_cmd_fsm (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .req_valid_i       (req_valid_i),
        .req_i             (req_i),
        .cmd_accept_i      (cmd_accept_i),
        .refresh_pending_i (refresh_pending),
        .row_hit_i         (row_hit),
        .bank_open_i       (bank_open),
        .any_open_i        (any_open),
        .id_space_i        (id_space),
        .cmd_o             (cmd_o),
        .req_accept_o      (req_accept_o),
        .refresh_done_o    (refresh_done),
        .push_o            (push),
        .write_issued_o    (write_issued),
        .update_o          (bank_update),
        .bank_o            (lookup_bank),
        .row_o             (lookup_row)
    );

    ddr_bank_tracker u_bank_tracker (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .update_i    (bank_update),
        .bank_i      (lookup_bank),
        .row_i       (lookup_row),
        .row_hit_o   (row_hit),
        .bank_open_o (bank_open),
        .any_open_o  (any_open)
    );

    ddr_resp_tracker u_resp_tracker (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .push_i         (push),
        .id_i           (req_i.id),
        .write_issued_i (write_issued),
        .rd_valid_i     (rd_valid_i),
        .rd_data_i      (rd_data_i),
        .id_space_o     (id_space),
        .resp_valid_o   (resp_valid_o),
        .resp_o         (resp_o)
    );

endmodule

`default_nettype wire

/* rtl/ddr_refresh_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_ctrl_params.svh"

module ddr_refresh_timer
    import ddr_ctrl_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic refresh_done_i,
    output logic      refresh_pending_o
);

    localparam int unsigned CNT_W = `DDR_REFRESH_CNT_W;

    // Reload values
    // Interval load is one short because the zero count takes a cycle too
    localparam logic [CNT_W-1:0] START_LOAD   = CNT_W'(`DDR_START_DELAY);
    localparam logic [CNT_W-1:0] REFRESH_LOAD = CNT_W'(`DDR_REFRESH_CYCLES - 1);

    logic [CNT_W-1:0] timer_q;
    logic             tick;

    // Tick when the down counter runs out
    assign tick = (timer_q == '0);

    // Start delay first, then the fixed interval
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            timer_q <= START_LOAD;
        else if (tick)
            timer_q <= REFRESH_LOAD;
        else
            timer_q <= timer_q - 1'b1;
    end

    // Pending until the FSM has issued REFRESH
    // A new tick wins over a completion in the same cycle
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            refresh_pending_o <= 1'b0;
        else if (tick)
            refresh_pending_o <= 1'b1;
        else if (refresh_done_i)
            refresh_pending_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* rtl/ddr_resp_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_ctrl_params.svh"

module ddr_resp_tracker
    import ddr_ctrl_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    input  wire logic     push_i,
    input  wire req_id_t  id_i,
    input  wire logic     write_issued_i,
    input  wire logic     rd_valid_i,
    input  wire rd_data_t rd_data_i,
    output logic          id_space_o,
    output logic          resp_valid_o,
    output host_resp_t    resp_o
);

    localparam int unsigned DEPTH = `ID_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);

    req_id_t          id_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    // Reads accepted but not yet returned
    logic [PTR_W:0]   rd_out_q;
    logic             write_ack_q;
    logic             pop;

    // Write acknowledge one cycle after the WRITE command
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            write_ack_q <= 1'b0;
        else
            write_ack_q <= write_issued_i;
    end

    assign pop = write_ack_q || rd_valid_i;

    // --------------------------------------------------
    // ID FIFO
    // --------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (push_i)
            id_mem[wr_ptr_q] <= id_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            rd_out_q <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // A push without a WRITE is a read
            case ({push_i && !write_issued_i, rd_valid_i})
                2'b10:   rd_out_q <= rd_out_q + 1'b1;
                2'b01:   rd_out_q <= rd_out_q - 1'b1;
                default: rd_out_q <= rd_out_q;
            endcase
        end
    end

    // Hold new requests while read data is outstanding
    // so a write acknowledge never overtakes a read
    assign id_space_o = (count_q != (PTR_W+1)'(DEPTH)) && (rd_out_q == '0);

    // Responses leave in request order
    assign resp_valid_o   = pop;
    assign resp_o.id      = id_mem[rd_ptr_q];
    assign resp_o.rd_data = rd_data_i;

    // Every acknowledge matches an accepted request
    no_pop_when_empty: assert property (
        @(posedge clk_i) disable iff (rst_i)
        pop |-> (count_q != '0)
    );

    // FSM respects the space flag
    no_push_when_full: assert property (
        @(posedge clk_i) disable iff (rst_i)
        push_i |-> (count_q != (PTR_W+1)'(DEPTH))
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the DDR controller testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module ddr_ctrl_tb \
    -f ddr_ctrl.f \
    -o ddr_ctrl_sim

./obj_dir/ddr_ctrl_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi
echo "Run finished without failures"

/* verification/ddr_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_ctrl_params.svh"

module ddr_ctrl_tb
    import ddr_ctrl_pkg::*;
();

    localparam int          NUM_REQ    = 60;
    localparam int          CLK_HALF   = 10;
    localparam int          RST_CYCLES = 3;
    localparam int unsigned SEED       = 32'h88577440;
    // Per-request budget plus room for the start delay and refreshes
    localparam int TIMEOUT_CYCLES = NUM_REQ * 40 + `DDR_START_DELAY + 2 * `DDR_REFRESH_CYCLES;

    typedef struct packed {
        req_id_t    id;
        logic       rd;
        host_addr_t addr;
        int         acc_cycle;
    } exp_resp_t;

    typedef struct packed {
        int       due;
        rd_data_t data;
    } rd_return_t;

    logic       clk_i;
    logic       rst_i;
    logic       req_valid_i;
    host_req_t  req_i;
    logic       req_accept_o;
    logic       resp_valid_o;
    host_resp_t resp_o;
    ddr_cmd_t   cmd_o;
    logic       cmd_accept_i;
    logic       rd_valid_i;
    rd_data_t   rd_data_i;

    // Reference state
    ddr_cmd_t   exp_cmds [$];
    exp_resp_t  exp_resps [$];
    host_req_t  host_q [$];
    rd_return_t rd_ret_q [$];
    logic       model_open [`DDR_BANKS];
    ddr_row_t   model_row [`DDR_BANKS];

    int         cycle_cnt;
    int         errors;
    int         checks;
    int         sent;
    int         resp_count;
    int         ref_count;
    int         pre_all_count;
    logic       seen_cmd;
    logic       hold_pending;
    ddr_cmd_t   held_cmd;

    ddr_ctrl_top u_ddr_ctrl_top (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_accept_o (req_accept_o),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .cmd_o        (cmd_o),
        .cmd_accept_i (cmd_accept_i),
        .rd_valid_i   (rd_valid_i),
        .rd_data_i    (rd_data_i)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Reporting
    // --------------------------------------------------
    task automatic report_mismatch(string name, logic [127:0] exp_v, logic [127:0] act_v);
        errors++;
        $display("FAIL at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
    endtask

    task automatic report_error(string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic ddr_cmd_t make_cmd(ddr_cmd_e cmd, ddr_bank_t bank, ddr_addr_t addr);
        ddr_cmd_t c;
        c.cmd  = cmd;
        c.bank = bank;
        c.addr = addr;
        return c;
    endfunction

    // Fixed data rule of the sequencer model
    function automatic rd_data_t read_pattern(host_addr_t a);
        return {a, ~a, a ^ 32'h5A5A_C3C3, a[15:0], a[31:16]};
    endfunction

    // Commands for one request, from the open-row table
    function automatic void expect_access(host_req_t r);
        ddr_bank_t b;
        ddr_row_t  row;
        ddr_addr_t col_addr;
        b        = r.addr[13:11];
        row      = r.addr[28:14];
        col_addr = '0;
        // Column 9..3 from address 10..4, bit 10 clear so no auto-precharge
        col_addr[9:3] = r.addr[10:4];
        // Row conflict closes the bank first
        if (model_open[b] && model_row[b] != row)
        begin
            exp_cmds.push_back(make_cmd(CMD_PRECHARGE, b, '0));
            model_open[b] = 1'b0;
        end
        if (!model_open[b])
        begin
            exp_cmds.push_back(make_cmd(CMD_ACTIVE, b, row));
            model_open[b] = 1'b1;
            model_row[b]  = row;
        end
        exp_cmds.push_back(make_cmd(r.rd ? CMD_READ : CMD_WRITE, b, col_addr));
    endfunction

    // Refresh, with all-banks precharge when any row is open
    function automatic void expect_refresh();
        logic any_open;
        any_open = 1'b0;
        for (int i = 0; i < `DDR_BANKS; i++)
            any_open = any_open | model_open[i];
        if (any_open)
        begin
            // Address bit 10 selects all banks
            exp_cmds.push_back(make_cmd(CMD_PRECHARGE, '0, 15'h0400));
            pre_all_count++;
        end
        exp_cmds.push_back(make_cmd(CMD_REFRESH, '0, '0));
        for (int i = 0; i < `DDR_BANKS; i++)
            model_open[i] = 1'b0;
    endfunction

    // --------------------------------------------------
    // Stimulus and sequencer model
    // --------------------------------------------------
    // Few banks and rows so hits, misses and conflicts all happen
    function automatic host_req_t make_request(int n);
        host_req_t r;
        ddr_row_t  row;
        ddr_bank_t bank;
        logic [6:0] col;
        r.rd = 1'($urandom % 2);
        r.wr = !r.rd;
        case ($urandom % 3)
            0:       row = 15'h0012;
            1:       row = 15'h2345;
            default: row = 15'h7ABC;
        endcase
        bank   = ddr_bank_t'($urandom % 3);
        col    = 7'($urandom);
        r.addr = {3'b000, row, bank, col, 4'b0000};
        r.id   = 16'h0100 + 16'(n);
        return r;
    endfunction

    task automatic drive_inputs();
        host_req_t r;
        // About 70 percent accept
        cmd_accept_i = ($urandom % 100) < 70;
        if (rd_ret_q.size() != 0 && rd_ret_q[0].due <= cycle_cnt)
        begin
            rd_valid_i = 1'b1;
            rd_data_i  = rd_ret_q[0].data;
            void'(rd_ret_q.pop_front());
        end
        else
        begin
            rd_valid_i = 1'b0;
            rd_data_i  = '0;
        end
        // Request taken by the DUT
        if (req_valid_i && host_q.size() == 0)
            req_valid_i = 1'b0;
        if (!req_valid_i && sent < NUM_REQ && ($urandom % 4) != 0)
        begin
            r           = make_request(sent);
            req_i       = r;
            req_valid_i = 1'b1;
            host_q.push_back(r);
            sent++;
        end
    endtask

    // Read data 2 to 6 cycles after the accept edge, in order
    task automatic schedule_read(host_addr_t a);
        rd_return_t e;
        e.due  = cycle_cnt + 3 + int'($urandom % 5);
        e.data = read_pattern(a);
        if (rd_ret_q.size() != 0 && e.due <= rd_ret_q[$].due)
            e.due = rd_ret_q[$].due + 1;
        rd_ret_q.push_back(e);
    endtask

    // --------------------------------------------------
    // Checks, sampled mid-cycle
    // --------------------------------------------------
    task automatic check_hold();
        checks++;
        if (hold_pending && cmd_o != held_cmd)
            report_mismatch("cmd_o (held)", 128'(held_cmd), 128'(cmd_o));
        hold_pending = (cmd_o.cmd != CMD_NOP) && !cmd_accept_i;
        held_cmd     = cmd_o;
    endtask

    // Picks refresh or access from the first command of a sequence
    task automatic start_sequence();
        if (cmd_o.cmd == CMD_REFRESH || (cmd_o.cmd == CMD_PRECHARGE && cmd_o.addr[10]))
        begin
            if (cycle_cnt < `DDR_START_DELAY + ref_count * `DDR_REFRESH_CYCLES)
                report_error("refresh sequence started before its refresh tick");
            ref_count++;
            expect_refresh();
        end
        else if (host_q.size() == 0)
            report_error("command issued with no host request pending");
        else
            expect_access(host_q[0]);
        if (!seen_cmd && cmd_o.cmd != CMD_REFRESH)
            report_error("first command after reset is not REFRESH");
        seen_cmd = 1'b1;
    endtask

    task automatic check_command();
        exp_resp_t e;
        ddr_cmd_t  exp_c;
        logic      exp_accept;
        exp_accept = 1'b0;
        if (cycle_cnt < `DDR_START_DELAY && cmd_o.cmd != CMD_NOP)
            report_error("command issued before the first refresh tick");
        if (cmd_accept_i && cmd_o.cmd != CMD_NOP)
        begin
            if (exp_cmds.size() == 0)
                start_sequence();
            if (exp_cmds.size() != 0)
            begin
                exp_c = exp_cmds.pop_front();
                checks++;
                if (cmd_o != exp_c)
                    report_mismatch("cmd_o", 128'(exp_c), 128'(cmd_o));
                // Host accept belongs to the accepted access of the model
                exp_accept = (exp_c.cmd == CMD_READ || exp_c.cmd == CMD_WRITE);
            end
            if (cmd_o.cmd == CMD_READ && host_q.size() != 0)
                schedule_read(host_q[0].addr);
        end
        checks++;
        if (req_accept_o != exp_accept)
            report_mismatch("req_accept_o", 128'(exp_accept), 128'(req_accept_o));
        if (req_accept_o)
        begin
            if (host_q.size() == 0)
                report_error("req_accept_o high with no request pending");
            else
            begin
                e.id        = host_q[0].id;
                e.rd        = host_q[0].rd;
                e.addr      = host_q[0].addr;
                e.acc_cycle = cycle_cnt;
                exp_resps.push_back(e);
                void'(host_q.pop_front());
            end
        end
    endtask

    task automatic check_response();
        exp_resp_t e;
        if (rd_valid_i && !resp_valid_o)
            report_error("read data returned without a host response");
        if (resp_valid_o)
        begin
            resp_count++;
            if (exp_resps.size() == 0)
                report_error("host response with no outstanding request");
            else
            begin
                e = exp_resps.pop_front();
                checks++;
                if (resp_o.id != e.id)
                    report_mismatch("resp_o.id", 128'(e.id), 128'(resp_o.id));
                if (e.rd)
                begin
                    checks++;
                    if (!rd_valid_i)
                        report_error("read response without returned read data");
                    if (resp_o.rd_data != read_pattern(e.addr))
                        report_mismatch("resp_o.rd_data", read_pattern(e.addr), resp_o.rd_data);
                end
                else
                begin
                    // One cycle after the WRITE accept
                    checks++;
                    if (cycle_cnt != e.acc_cycle + 1)
                        report_error("write response not one cycle after WRITE accept");
                end
            end
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin
        int tail;
        int min_ref;
        void'($urandom(SEED));
        rst_i         = 1'b1;
        req_valid_i   = 1'b0;
        req_i         = '0;
        cmd_accept_i  = 1'b0;
        rd_valid_i    = 1'b0;
        rd_data_i     = '0;
        cycle_cnt     = 0;
        errors        = 0;
        checks        = 0;
        sent          = 0;
        resp_count    = 0;
        ref_count     = 0;
        pre_all_count = 0;
        seen_cmd      = 1'b0;
        hold_pending  = 1'b0;
        held_cmd      = '0;
        tail          = 0;
        for (int i = 0; i < `DDR_BANKS; i++)
        begin
            model_open[i] = 1'b0;
            model_row[i]  = '0;
        end
        repeat (RST_CYCLES) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        drive_inputs();
        // Run until every response is back and no sequence is half done
        while (resp_count < NUM_REQ || tail < 10 || exp_cmds.size() != 0)
        begin
            @(negedge clk_i);
            check_hold();
            check_command();
            check_response();
            @(posedge clk_i);
            cycle_cnt++;
            if (resp_count >= NUM_REQ)
                tail++;
            #1;
            drive_inputs();
        end
        if (exp_resps.size() != 0 || host_q.size() != 0)
            report_error("requests left without a response");
        // Refresh must keep recurring over the run
        min_ref = 1;
        if (cycle_cnt > `DDR_START_DELAY + 100)
            min_ref = 1 + (cycle_cnt - `DDR_START_DELAY - 100) / `DDR_REFRESH_CYCLES;
        if (ref_count < min_ref)
            report_error("too few refresh sequences for the run length");
        $display("checks=%0d errors=%0d refreshes=%0d precharge_all=%0d responses=%0d",
                 checks, errors, ref_count, pre_all_count, resp_count);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TIMEOUT_CYCLES * 2 * CLK_HALF);
        $display("ERROR at %0t: watchdog expired with %0d of %0d responses seen",
                 $time, resp_count, NUM_REQ);
        $display("checks=%0d errors=%0d refreshes=%0d precharge_all=%0d responses=%0d",
                 checks, errors + 1, ref_count, pre_all_count, resp_count);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
